// File: hdl/pokey_reg_pkg.sv
// pokey register map
package pokey_reg_pkg;

    typedef logic [3:0] reg_addr_t;  // cpu register address, a3..a0
    typedef logic [7:0] reg_byte_t;  // data bus byte

    // read side
    localparam reg_addr_t ADDR_POT0   = 4'd0;  // pot0..pot7 sit at 0..7
    localparam reg_addr_t ADDR_ALLPOT = 4'd8;  // one bit per pot still counting
    localparam reg_addr_t ADDR_KBCODE = 4'd9;  // last debounced key code
    localparam reg_addr_t ADDR_SKSTAT = 4'd15; // serial / keyboard status

    // write side
    localparam reg_addr_t ADDR_POTGO  = 4'd11; // write only, data ignored

    // skstat layout, active low flags
    localparam int SKSTAT_KEY_BIT = 2;         // low while a key is held

    // bus value for addresses with nothing behind them
    localparam reg_byte_t OPEN_BUS = 8'hff;

endpackage

// File: hdl/pokey_io_pkg.sv
// keyboard and paddle value types
package pokey_io_pkg;

    // keyboard
    typedef logic [5:0] key_code_t;   // scan position, also the latched key code

    // paddles
    typedef logic [7:0] pot_value_t;  // line count captured per pot
    typedef logic [7:0] pot_lines_t;  // one bit per pot input

    // keyboard debounce FSM states
    typedef enum logic [1:0] {
        KEY_IDLE    = 2'd0,  // nothing pending
        KEY_SEEN    = 2'd1,  // candidate seen once, waiting for next pass
        KEY_HELD    = 2'd2,  // confirmed, kbcode latched
        KEY_UP_SEEN = 2'd3   // held key read up once
    } key_state_t;

endpackage

// File: hdl/scan_timer.sv
// key scan and paddle line timer
`timescale 1ns/10ps

module scan_timer #(
    parameter int LINE_CYCLES = 114,  // o2 clocks per paddle line
    parameter int POT_LINES   = 228   // lines per paddle scan
) (
    input  logic                   o2,
    input  logic                   rst,
    input  logic                   potgo,        // start or restart paddle scan
    output pokey_io_pkg::key_code_t  key_code,   // current matrix scan position
    output logic                   pass_end,     // last code of a pass
    output pokey_io_pkg::pot_value_t pot_count,  // current paddle line
    output logic                   scan_active,
    output logic                   scan_done     // end of scan strobe
);

    localparam int PW = $clog2(LINE_CYCLES + 1);

    logic [PW-1:0] prescale;  // clocks into the current line
    logic          line_tick;
    logic          last_line;

    // keyboard scan counter, free running, wraps 63 -> 0
    always_ff @(posedge o2) begin
        if (rst) begin
            key_code <= '0;
        end else begin
            key_code <= key_code + 1'b1;
        end
    end

    assign pass_end = (key_code == '1);

    // prescaler runs 0..LINE_CYCLES on the first line and 1..LINE_CYCLES after,
    // so line 0 lasts one extra clock and lines line up with the pot_dump fall
    assign line_tick = scan_active && (prescale == PW'(LINE_CYCLES));
    assign last_line = (pot_count == pokey_io_pkg::pot_value_t'(POT_LINES - 1));
    assign scan_done = line_tick && last_line && !potgo;  // restart wins

    always_ff @(posedge o2) begin
        if (rst) begin
            prescale    <= '0;
            pot_count   <= '0;
            scan_active <= 1'b0;
        end else if (potgo) begin
            prescale    <= '0;    // new scan from line 0
            pot_count   <= '0;
            scan_active <= 1'b1;
        end else if (scan_active) begin
            if (line_tick) begin
                prescale  <= PW'(1);
                pot_count <= pot_count + 1'b1;    // holds POT_LINES after the end
                if (last_line)
                    scan_active <= 1'b0;          // same edge that raises pot_dump
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

// File: hdl/key_debounce_fsm.sv
// keyboard debounce FSM
`timescale 1ns/10ps

module key_debounce_fsm (
    input  logic                    o2,
    input  logic                    rst,
    input  pokey_io_pkg::key_code_t key_code,  // scan position this cycle
    input  logic                    pass_end,  // key_code is 63
    input  logic                    kr1_n,     // matrix return, low = key down
    output pokey_io_pkg::key_code_t kbcode,    // debounced code
    output logic                    key_held,
    output logic                    key_irq    // one clock on accept
);

    pokey_io_pkg::key_state_t state;
    pokey_io_pkg::key_code_t  cand;       // code of the first sighting
    logic                     pass_mark;  // one pass_end passed while in KEY_SEEN
    logic                     key_down;
    logic                     at_cand;
    logic                     at_kbcode;

    assign key_down  = !kr1_n;
    assign at_cand   = (key_code == cand);
    assign at_kbcode = (key_code == kbcode);

    // held flag covers the whole release debounce too
    assign key_held = (state == pokey_io_pkg::KEY_HELD) ||
                      (state == pokey_io_pkg::KEY_UP_SEEN);

    // candidate code, only loaded on a first sighting
    always_ff @(posedge o2) begin
        if (state == pokey_io_pkg::KEY_IDLE && key_down)
            cand <= key_code;
    end

    always_ff @(posedge o2) begin
        if (rst) begin
            state     <= pokey_io_pkg::KEY_IDLE;
            pass_mark <= 1'b0;
            kbcode    <= '0;
            key_irq   <= 1'b0;
        end else begin
            key_irq <= 1'b0;  // default, pulses below
            case (state)
                pokey_io_pkg::KEY_IDLE: begin
                    if (key_down) begin
                        state     <= pokey_io_pkg::KEY_SEEN;
                        pass_mark <= 1'b0;
                    end
                end
                pokey_io_pkg::KEY_SEEN: begin
                    if (at_cand) begin
                        if (key_down) begin
                            state   <= pokey_io_pkg::KEY_HELD;  // second sighting, accept
                            kbcode  <= cand;
                            key_irq <= 1'b1;
                        end else begin
                            state <= pokey_io_pkg::KEY_IDLE;    // bounce, drop it
                        end
                    end else if (pass_end) begin
                        // a whole pass without the candidate drops it
                        if (pass_mark)
                            state <= pokey_io_pkg::KEY_IDLE;
                        pass_mark <= 1'b1;
                    end
                end
                pokey_io_pkg::KEY_HELD: begin
                    if (at_kbcode && !key_down)
                        state <= pokey_io_pkg::KEY_UP_SEEN;  // first up pass
                end
                pokey_io_pkg::KEY_UP_SEEN: begin
                    if (at_kbcode)
                        state <= key_down ? pokey_io_pkg::KEY_HELD  // still bouncing
                                          : pokey_io_pkg::KEY_IDLE; // released, kbcode kept
                end
                default: state <= pokey_io_pkg::KEY_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/pot_capture.sv
// paddle capture latches
`timescale 1ns/10ps

module pot_capture #(
    parameter int POT_LINES = 228  // value of a pot that never rose
) (
    input  logic                     o2,
    input  logic                     rst,
    input  logic                     potgo,
    input  logic                     scan_active,
    input  logic                     scan_done,
    input  pokey_io_pkg::pot_value_t pot_count,
    input  pokey_io_pkg::pot_lines_t pot_scan,   // comparator outputs, async
    output pokey_io_pkg::pot_value_t pot0,
    output pokey_io_pkg::pot_value_t pot1,
    output pokey_io_pkg::pot_value_t pot2,
    output pokey_io_pkg::pot_value_t pot3,
    output pokey_io_pkg::pot_value_t pot4,
    output pokey_io_pkg::pot_value_t pot5,
    output pokey_io_pkg::pot_value_t pot6,
    output pokey_io_pkg::pot_value_t pot7,
    output pokey_io_pkg::pot_lines_t allpot,     // 1 = pot still counting
    output logic                     pot_dump    // high shorts the caps
);

    pokey_io_pkg::pot_lines_t pot_scan_q;
    pokey_io_pkg::pot_value_t pot_q [8];

    assign pot0 = pot_q[0];
    assign pot1 = pot_q[1];
    assign pot2 = pot_q[2];
    assign pot3 = pot_q[3];
    assign pot4 = pot_q[4];
    assign pot5 = pot_q[5];
    assign pot6 = pot_q[6];
    assign pot7 = pot_q[7];

    always_ff @(posedge o2) begin
        if (rst) begin
            pot_scan_q <= '0;
            allpot     <= '0;
            pot_dump   <= 1'b1;  // caps held empty
            for (int i = 0; i < 8; i++)
                pot_q[i] <= '0;
        end else begin
            pot_scan_q <= pot_dump ? '0 : pot_scan;  // dumped caps read low
            if (potgo) begin
                pot_dump <= 1'b1;   // dump again, release follows next clock
                allpot   <= '0;
                for (int i = 0; i < 8; i++)
                    pot_q[i] <= '0;
            end else if (scan_active && pot_dump) begin
                pot_dump <= 1'b0;   // release, line 0 starts
                allpot   <= '1;
            end else if (scan_active) begin
                for (int i = 0; i < 8; i++) begin
                    // first registered rise wins, end of scan fills the rest
                    if (allpot[i] && (pot_scan_q[i] || scan_done)) begin
                        pot_q[i]  <= pot_scan_q[i] ? pot_count
                                                   : pokey_io_pkg::pot_value_t'(POT_LINES);
                        allpot[i] <= 1'b0;
                    end
                end
                if (scan_done)
                    pot_dump <= 1'b1;  // scan over
            end
        end
    end

endmodule

// File: hdl/io_regs.sv
// cpu register port
`timescale 1ns/10ps

module io_regs (
    input  pokey_reg_pkg::reg_addr_t addr,
    input  logic                     wr,        // one clock write strobe
    input  pokey_reg_pkg::reg_byte_t wr_data,   // potgo is data-less, not decoded
    input  pokey_io_pkg::pot_value_t pot0,
    input  pokey_io_pkg::pot_value_t pot1,
    input  pokey_io_pkg::pot_value_t pot2,
    input  pokey_io_pkg::pot_value_t pot3,
    input  pokey_io_pkg::pot_value_t pot4,
    input  pokey_io_pkg::pot_value_t pot5,
    input  pokey_io_pkg::pot_value_t pot6,
    input  pokey_io_pkg::pot_value_t pot7,
    input  pokey_io_pkg::pot_lines_t allpot,
    input  pokey_io_pkg::key_code_t  kbcode,
    input  logic                     key_held,
    output pokey_reg_pkg::reg_byte_t data_out,  // combinational on addr
    output logic                     potgo
);

    // write decode, any value written to POTGO starts a scan
    assign potgo = wr && (addr == pokey_reg_pkg::ADDR_POTGO);

    // read mux
    always_comb begin
        data_out = pokey_reg_pkg::OPEN_BUS;
        case (addr)
            pokey_reg_pkg::ADDR_POT0:         data_out = pot0;
            pokey_reg_pkg::ADDR_POT0 + 4'd1:  data_out = pot1;
            pokey_reg_pkg::ADDR_POT0 + 4'd2:  data_out = pot2;
            pokey_reg_pkg::ADDR_POT0 + 4'd3:  data_out = pot3;
            pokey_reg_pkg::ADDR_POT0 + 4'd4:  data_out = pot4;
            pokey_reg_pkg::ADDR_POT0 + 4'd5:  data_out = pot5;
            pokey_reg_pkg::ADDR_POT0 + 4'd6:  data_out = pot6;
            pokey_reg_pkg::ADDR_POT0 + 4'd7:  data_out = pot7;
            pokey_reg_pkg::ADDR_ALLPOT:       data_out = allpot;
            pokey_reg_pkg::ADDR_KBCODE:       data_out = pokey_reg_pkg::reg_byte_t'(kbcode);
            pokey_reg_pkg::ADDR_SKSTAT: begin
                data_out = '1;  // serial flags not built, idle high
                data_out[pokey_reg_pkg::SKSTAT_KEY_BIT] = !key_held;  // active low
            end
            default: ;  // open bus
        endcase
    end

endmodule

// File: hdl/pokey_io_top.sv
// pokey keyboard and paddle block
`timescale 1ns/10ps

module pokey_io_top #(
    parameter int LINE_CYCLES = 114,  // ntsc line time in o2 clocks
    parameter int POT_LINES   = 228
) (
    input  logic                     o2,
    input  logic                     rst,
    input  pokey_reg_pkg::reg_addr_t addr,
    input  logic                     wr,
    input  pokey_reg_pkg::reg_byte_t wr_data,
    input  logic                     kr1_n,
    input  pokey_io_pkg::pot_lines_t pot_scan,
    output pokey_reg_pkg::reg_byte_t data_out,
    output pokey_io_pkg::key_code_t  key_scan,  // to the matrix decoder
    output logic                     key_irq,
    output logic                     pot_dump
);

    logic                     potgo;
    logic                     pass_end;
    logic                     scan_active;
    logic                     scan_done;
    logic                     key_held;
    pokey_io_pkg::pot_value_t pot_count;
    pokey_io_pkg::key_code_t  kbcode;
    pokey_io_pkg::pot_lines_t allpot;
    pokey_io_pkg::pot_value_t pot0, pot1, pot2, pot3;
    pokey_io_pkg::pot_value_t pot4, pot5, pot6, pot7;

    // timing for both halves
    scan_timer #(.LINE_CYCLES(LINE_CYCLES), .POT_LINES(POT_LINES)) u_timer (
        .o2(o2), .rst(rst), .potgo(potgo),
        .key_code(key_scan), .pass_end(pass_end),   // scan code goes straight out
        .pot_count(pot_count), .scan_active(scan_active), .scan_done(scan_done)
    );

    key_debounce_fsm u_key (
        .o2(o2), .rst(rst), .key_code(key_scan), .pass_end(pass_end), .kr1_n(kr1_n),
        .kbcode(kbcode), .key_held(key_held), .key_irq(key_irq)
    );

    pot_capture #(.POT_LINES(POT_LINES)) u_pot (
        .o2(o2), .rst(rst), .potgo(potgo), .scan_active(scan_active),
        .scan_done(scan_done), .pot_count(pot_count), .pot_scan(pot_scan),
        .pot0(pot0), .pot1(pot1), .pot2(pot2), .pot3(pot3),
        .pot4(pot4), .pot5(pot5), .pot6(pot6), .pot7(pot7),
        .allpot(allpot), .pot_dump(pot_dump)
    );

    io_regs u_regs (
        .addr(addr), .wr(wr), .wr_data(wr_data),
        .pot0(pot0), .pot1(pot1), .pot2(pot2), .pot3(pot3),
        .pot4(pot4), .pot5(pot5), .pot6(pot6), .pot7(pot7),
        .allpot(allpot), .kbcode(kbcode), .key_held(key_held),
        .data_out(data_out), .potgo(potgo)
    );

endmodule

// File: testbench/pokey_io_checker.sv
// keyboard and paddle assertions
`timescale 1ns/10ps

module pokey_io_checker (
    input logic                     o2,
    input logic                     rst,
    input logic                     key_irq,
    input logic                     key_held,
    input logic                     pot_dump,
    input logic                     scan_active,
    input pokey_io_pkg::pot_lines_t allpot
);

    // accept strobe is one clock wide
    irq_pulse: assert property (@(posedge o2) disable iff (rst) key_irq |=> !key_irq)
        else $error("key_irq high for more than one cycle");

    // skstat key bit is !key_held, so it must fall with the strobe
    irq_with_key_bit: assert property (@(posedge o2) disable iff (rst)
        key_irq == $rose(key_held))
        else $error("key_irq and the SKSTAT key bit fall are not in the same cycle");

    dump_when_idle: assert property (@(posedge o2) disable iff (rst) !scan_active |-> pot_dump)
        else $error("pot_dump low with no paddle scan running");  // caps shorted between scans

    // no pot counts while the caps are dumped
    allpot_clear: assert property (@(posedge o2) disable iff (rst) pot_dump |-> allpot == '0)
        else $error("ALLPOT nonzero while pot_dump is high");

endmodule

bind pokey_io_top pokey_io_checker u_chk (
    .o2(o2), .rst(rst), .key_irq(key_irq), .key_held(key_held), .pot_dump(pot_dump),
    .scan_active(scan_active), .allpot(allpot)
);

// File: testbench/tb_pokey_io.sv
// keyboard and paddle testbench
`timescale 1ns/10ps

module tb_pokey_io;

    localparam int LINE_CYCLES = 4;    // short lines so a scan is about 900 clocks
    localparam int POT_LINES   = 228;

    logic                     o2, rst, wr, kr1_n, key_irq, pot_dump;
    pokey_reg_pkg::reg_addr_t addr;
    pokey_reg_pkg::reg_byte_t wr_data, data_out;
    pokey_io_pkg::key_code_t  key_scan;
    pokey_io_pkg::pot_lines_t pot_scan = '0;

    logic                     key_down;         // keyboard model holds one key at a time
    pokey_io_pkg::key_code_t  held_code;
    pokey_io_pkg::pot_value_t tgt [8];          // rise line per pot where ff never rises
    int                       dump_cnt = 0;     // clocks since pot_dump fell
    pokey_io_pkg::key_code_t  prev_scan;        // key_scan on the last clock
    logic                     scan_seen = 1'b0;
    logic [7:0]               vec_cmd [64];
    logic [15:0]              vec_arg [64][8];
    int                       vec_n;
    int                       cycles = 0;
    int                       cycle_limit = 0;  // 0 until the vectors are counted

    pokey_io_top #(.LINE_CYCLES(LINE_CYCLES), .POT_LINES(POT_LINES)) uut (
        .o2(o2), .rst(rst), .addr(addr), .wr(wr), .wr_data(wr_data), .kr1_n(kr1_n),
        .pot_scan(pot_scan), .data_out(data_out), .key_scan(key_scan),
        .key_irq(key_irq), .pot_dump(pot_dump)
    );

    always #10 o2 = !o2;  // 20 ns period

    assign kr1_n = !(key_down && key_scan == held_code);  // matrix row goes low on the held key

    // pot comparators where bit i rises LINE_CYCLES * tgt[i] clocks after the dump ends
    always @(posedge o2) begin
        if (pot_dump !== 1'b0) begin
            dump_cnt <= 0;
            pot_scan <= '0;  // shorted caps read low
        end else begin
            dump_cnt <= dump_cnt + 1;
            for (int i = 0; i < 8; i++)
                pot_scan[i] <= tgt[i] != 8'hff && dump_cnt + 1 >= LINE_CYCLES * tgt[i];
        end
    end

    // matrix scan steps one code per clock and wraps from 63 to 0
    always @(negedge o2) begin
        if (rst === 1'b0 && scan_seen)
            check_code(key_scan,
                       (prev_scan == 6'd63) ? pokey_io_pkg::key_code_t'(0)
                                            : pokey_io_pkg::key_code_t'(prev_scan + 6'd1),
                       "key_scan");
        prev_scan <= key_scan;
        scan_seen <= (rst === 1'b0);
    end

    always @(posedge o2) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout, the run was still going after %0d cycles", cycles);
            fail_run();
        end
    end

    task automatic fail_run;
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input pokey_reg_pkg::reg_byte_t got, exp, input string name);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_code(input pokey_io_pkg::key_code_t got, exp, input string name);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input logic got, exp, input string name);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // address goes out on the edge and data_out is read mid cycle
    task automatic read_reg(input pokey_reg_pkg::reg_addr_t a,
                            output pokey_reg_pkg::reg_byte_t v);
        @(posedge o2);
        addr <= a;
        @(negedge o2);
        v = data_out;
    endtask

    function automatic logic flag_now(input int which);
        case (which)
            0:       return key_irq;
            1:       return data_out[pokey_reg_pkg::SKSTAT_KEY_BIT];  // needs addr on SKSTAT
            default: return pot_dump;
        endcase
    endfunction

    // wait for a flag to read high within a limit in clocks
    task automatic wait_flag(input int which, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(negedge o2);
            n++;
        end while (flag_now(which) !== 1'b1 && n < limit);
        if (flag_now(which) !== 1'b1) begin
            $display("no %s within %0d clocks", what, limit);
            fail_run();
        end
    endtask

    task automatic load_vectors;
        int          fd, rc, nf;
        logic [7:0]  c;
        logic [31:0] v;
        string       line;
        vec_n = 0;
        fd = $fopen("testbench/pokey_io_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vectors file testbench/pokey_io_vectors.txt");
            fail_run();
        end else begin
            while ($fscanf(fd, " %c", c) == 1) begin
                if (c == "#") begin
                    rc = $fgets(line, fd);  // column notes
                end else begin
                    nf = (c == "G") ? 8 : (c == "C") ? 2 : (c == "P" || c == "I") ? 1 : 0;
                    vec_cmd[vec_n] = c;
                    for (int i = 0; i < nf; i++) begin
                        rc = $fscanf(fd, "%h", v);
                        vec_arg[vec_n][i] = v[15:0];
                    end
                    vec_n++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vectors;
        pokey_reg_pkg::reg_byte_t v;
        for (int k = 0; k < vec_n; k++) begin
            case (vec_cmd[k])
                "P": begin
                    @(posedge o2);
                    held_code <= pokey_io_pkg::key_code_t'(vec_arg[k][0]);
                    key_down  <= 1'b1;
                    addr      <= pokey_reg_pkg::ADDR_SKSTAT;  // watch the key bit
                    wait_flag(0, 128, "key_irq pulse after the key press");
                    check_bit(data_out[pokey_reg_pkg::SKSTAT_KEY_BIT], 1'b0, "SKSTAT key bit");
                    read_reg(pokey_reg_pkg::ADDR_KBCODE, v);
                    check_code(pokey_io_pkg::key_code_t'(v),
                               pokey_io_pkg::key_code_t'(vec_arg[k][0]), "KBCODE");
                end
                "R": begin
                    @(posedge o2);
                    key_down <= 1'b0;
                    addr     <= pokey_reg_pkg::ADDR_SKSTAT;
                    wait_flag(1, 192, "SKSTAT key bit return after the key release");
                end
                "G": begin
                    @(posedge o2);
                    addr <= pokey_reg_pkg::ADDR_POTGO;
                    wr   <= 1'b1;
                    for (int i = 0; i < 8; i++)
                        tgt[i] <= vec_arg[k][i][7:0];
                    @(posedge o2);  // strobe taken here
                    wr <= 1'b0;
                    @(negedge o2);
                    check_bit(pot_dump, 1'b1, "pot_dump");
                    @(negedge o2);
                    check_bit(pot_dump, 1'b0, "pot_dump");  // released one clock later
                end
                "C": begin
                    read_reg(pokey_reg_pkg::reg_addr_t'(vec_arg[k][0]), v);
                    check_byte(v, pokey_reg_pkg::reg_byte_t'(vec_arg[k][1]),
                               $sformatf("data_out at %h", vec_arg[k][0][3:0]));
                end
                "I": repeat (vec_arg[k][0]) @(posedge o2);
                "D": begin
                    wait_flag(2, LINE_CYCLES * POT_LINES + 8, "pot_dump rise at scan end");
                    for (int i = 0; i < 8; i++) begin
                        read_reg(pokey_reg_pkg::reg_addr_t'(pokey_reg_pkg::ADDR_POT0 + i), v);
                        // rise line or POT_LINES for a pot that never rose in the scan
                        check_byte(v, (tgt[i] >= POT_LINES) ? 8'(POT_LINES) : tgt[i],
                                   $sformatf("POT%0d", i));
                    end
                    read_reg(pokey_reg_pkg::ADDR_ALLPOT, v);
                    check_byte(v, '0, "ALLPOT");
                end
                default: begin
                    $display("unknown command letter %c in the vectors file", vec_cmd[k]);
                    fail_run();
                end
            endcase
        end
    endtask

    initial begin
        o2        = 1'b0;
        rst       = 1'b1;
        addr      = '0;
        wr        = 1'b0;
        wr_data   = '0;
        key_down  = 1'b0;
        held_code = '0;
        for (int i = 0; i < 8; i++)
            tgt[i] = 8'hff;
        load_vectors();
        cycle_limit = vec_n * 1200;
        repeat (10) @(posedge o2);
        rst <= 1'b0;
        @(negedge o2);
        check_bit(pot_dump, 1'b1, "pot_dump");  // caps dumped out of reset
        check_bit(key_irq, 1'b0, "key_irq");
        run_vectors();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: list.f
hdl/pokey_reg_pkg.sv
hdl/pokey_io_pkg.sv
hdl/scan_timer.sv
hdl/key_debounce_fsm.sv
hdl/pot_capture.sv
hdl/io_regs.sv
hdl/pokey_io_top.sv
testbench/pokey_io_checker.sv
testbench/tb_pokey_io.sv

// File: testbench/pokey_io_vectors.txt
# cmd and hex fields: P code | R | G t0..t7 (ff = never) | C addr expect | I cycles
# D waits for pot_dump to rise, then every pot is checked against its target
C 0f ff
C 08 00
C 00 00
C 09 00
P 2d
C 0f fb
I 20
C 09 2d
R
C 0f ff
C 09 2d
P 3f
R
C 09 3f
G 05 0a 14 ff 01 e3 64 c8
C 08 ff
D
G 10 20 30 ff 40 50 60 70
I 60
C 00 10
C 08 fe
G 08 09 0a 0b 0c 0d 0e ff
C 00 00
C 08 ff
D
C 07 e4
